//--- ks10Mem.f
rtl/ks10MemPkg.sv
rtl/clockPhase.sv
rtl/busDecode.sv
rtl/memStatus.sv
rtl/ssramPort.sv
rtl/memController.sv
rtl/ks10Mem.sv
sim/ssramModel.sv
sim/ks10Mem_properties.sv
sim/ks10MemTb.sv

//--- Makefile
# Verilator build, run, lint and clean for the KS10 memory controller
VERILATOR ?= verilator
TOP       ?= ks10MemTb
FILELIST  ?= ks10Mem.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
FAIL_MSG  ?= Checks failed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then exit 1; fi

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- sim/ks10MemTb.sv
// Directed testbench for the memory controller; runs bus cycles against an SRAM model
`timescale 1ns/1ps

module ks10MemTb;

   // KS10 bit n sits at bit 35-n in the MSR
   localparam ks10MemPkg::wordT   expPowerFail = 36'h1 << (35 - 12);
   localparam ks10MemPkg::wordT   expMask      = {12'hfff, 24'h0};
   localparam ks10MemPkg::ioAddrT expMsrAddr   = 18'o100000;
   localparam int                 numWords     = 16;
   localparam int                 phaseWait    = 8;       // Clocks

   logic                 clk;
   logic                 arstN;
   logic                 busReq;
   ks10MemPkg::busAddrT  busAddr;
   ks10MemPkg::wordT     busDataIn;
   logic                 busAck;
   ks10MemPkg::wordT     busDataOut;
   ks10MemPkg::phaseT    clkPhs;
   ks10MemPkg::ssramCtlT ssramCtl;
   ks10MemPkg::wordT     ssramDataIn;
   logic [31:0]          seed;
   int                   checkCnt;
   int                   errCnt;
   ks10MemPkg::wordT     memImage [ks10MemPkg::memAddrT];   // Scoreboard
   ks10MemPkg::memAddrT  addrList [$];

   ks10Mem i_ks10Mem (.*);

   ssramModel ssram (.clk(clk), .ssramCtl(ssramCtl), .ssramDataIn(ssramDataIn));

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] xorshift(input logic [31:0] s);
      logic [31:0] x;
      x = s ^ (s << 13);
      x = x ^ (x >> 17);
      return x ^ (x << 5);
   endfunction

   function automatic ks10MemPkg::busAddrT memWord(input int flag, input ks10MemPkg::memAddrT a);
      return (ks10MemPkg::busAddrT'(1) << flag) | ks10MemPkg::busAddrT'(a);
   endfunction

   // Physical IO word for a device and IO address
   function automatic ks10MemPkg::busAddrT ioWord(input int flag, input ks10MemPkg::devT dev,
                                                  input ks10MemPkg::ioAddrT a);
      ks10MemPkg::busAddrT w;
      w = ks10MemPkg::busAddrT'(1) << flag;
      w[ks10MemPkg::flagIo]   = 1'b1;
      w[ks10MemPkg::flagPhys] = 1'b1;
      w[ks10MemPkg::devLsb +: 4] = dev;
      w[17:0] = a;
      return w;
   endfunction

   task automatic checkVal(input string name, input ks10MemPkg::wordT got,
                           input ks10MemPkg::wordT exp);
      checkCnt++;
      if (got !== exp)
      begin
         errCnt++;
         $display("[FAIL] %s got %h expected %h", name, got, exp);
      end
   endtask

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("Checks failed");
      $finish;
   endtask

   task automatic testDone(input string name, input int errBefore);
      $display("%s test done, %0d error(s)", name, errCnt - errBefore);
   endtask

   // One four-clock cycle from phase 1, checked at phase 4
   task automatic busCycle(input ks10MemPkg::busAddrT addr, input ks10MemPkg::wordT data,
                           input logic req, input logic expAck, output ks10MemPkg::wordT rd);
      int n;
      n = 0;
      @(negedge clk);
      while (clkPhs != 4'b1000 && n < phaseWait)
      begin
         n++;
         @(negedge clk);
      end
      if (clkPhs != 4'b1000)
      begin
         abortRun("Timed out waiting for phase 4 before a bus cycle");
      end
      else
      begin
         @(posedge clk);                         // Phase 1 begins
         busReq    <= req;
         busAddr   <= addr;
         busDataIn <= data;
         repeat (3) @(posedge clk);
         @(negedge clk);                         // Middle of phase 4
         checkVal("busAck", ks10MemPkg::wordT'(busAck), ks10MemPkg::wordT'(expAck));
         rd = busDataOut;
         @(posedge clk);
         busReq <= 1'b0;
      end
   endtask

   task automatic resetTest();
      int               e;
      ks10MemPkg::wordT rd;
      e = errCnt;
      @(negedge clk);
      checkVal("clkPhs", ks10MemPkg::wordT'(clkPhs), 36'h1);   // Phase 1 in the first clock
      checkVal("busAck", ks10MemPkg::wordT'(busAck), '0);
      checkVal("ssramCtl.weN", ks10MemPkg::wordT'(ssramCtl.weN), 36'h1);
      checkVal("ssramCtl.dataOe", ks10MemPkg::wordT'(ssramCtl.dataOe), '0);
      busCycle(ioWord(ks10MemPkg::flagRead, 4'd0, expMsrAddr), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, expPowerFail);   // Power-fail alone
      testDone("reset", e);
   endtask

   task automatic memTest();
      int                  e;
      ks10MemPkg::memAddrT a;
      ks10MemPkg::wordT    d;
      ks10MemPkg::wordT    rd;
      e = errCnt;
      for (int i = 0; i < numWords; i++)
      begin
         seed = xorshift(seed);
         a = seed[19:0];
         d[35:32] = seed[23:20];
         seed = xorshift(seed);
         d[31:0] = seed;
         busCycle(memWord(ks10MemPkg::flagWrite, a), d, 1'b1, 1'b1, rd);
         memImage[a] = d;
         addrList.push_back(a);
      end
      foreach (addrList[i])
      begin
         busCycle(memWord(ks10MemPkg::flagRead, addrList[i]), '0, 1'b1, 1'b1, rd);
         checkVal("busDataOut", rd, memImage[addrList[i]]);
      end
      testDone("memory", e);
   endtask

   task automatic wrTestCycleTest();
      int                  e;
      ks10MemPkg::memAddrT a;
      ks10MemPkg::wordT    rd;
      e = errCnt;
      a = addrList[0];
      // Inverted data on the bus must not land
      busCycle(memWord(ks10MemPkg::flagWrTest, a), ~memImage[a], 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, memImage[a]);
      busCycle(memWord(ks10MemPkg::flagRead, a), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, memImage[a]);
      testDone("write-test", e);
   endtask

   task automatic msrTest();
      int               e;
      ks10MemPkg::wordT rd;
      e = errCnt;
      busCycle(ioWord(ks10MemPkg::flagWrite, 4'd0, expMsrAddr), '1, 1'b1, 1'b1, rd);
      busCycle(ioWord(ks10MemPkg::flagRead, 4'd0, expMsrAddr), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, expMask);        // W1C took power-fail
      busCycle(ioWord(ks10MemPkg::flagWrite, 4'd0, expMsrAddr), '0, 1'b1, 1'b1, rd);
      busCycle(ioWord(ks10MemPkg::flagRead, 4'd0, expMsrAddr), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, '0);
      testDone("MSR", e);
   endtask

   task automatic ignoreTest();
      int                  e;
      ks10MemPkg::memAddrT a;
      ks10MemPkg::wordT    d;
      ks10MemPkg::wordT    rd;
      e = errCnt;
      a = addrList[1];
      d = 36'h5a5a5a5a5;
      busCycle(ioWord(ks10MemPkg::flagWrite, 4'd0, expMsrAddr), 36'ha5a000000, 1'b1, 1'b1, rd);
      busCycle(memWord(ks10MemPkg::flagWrite, a), d, 1'b1, 1'b1, rd);
      // Wrong device, wrong IO address, no request
      busCycle(ioWord(ks10MemPkg::flagWrite, 4'd1, expMsrAddr), '1, 1'b1, 1'b0, rd);
      busCycle(ioWord(ks10MemPkg::flagWrite, 4'd0, expMsrAddr + 18'o1), '1, 1'b1, 1'b0, rd);
      busCycle(memWord(ks10MemPkg::flagWrite, a), ~d, 1'b0, 1'b0, rd);
      busCycle(ioWord(ks10MemPkg::flagRead, 4'd0, expMsrAddr), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, 36'ha5a000000);
      busCycle(memWord(ks10MemPkg::flagRead, a), '0, 1'b1, 1'b1, rd);
      checkVal("busDataOut", rd, d);
      testDone("unowned cycle", e);
   endtask

   initial
   begin
      arstN     = 1'b0;
      busReq    = 1'b0;
      busAddr   = '0;
      busDataIn = '0;
      seed      = 32'h1c1e02fe;
      checkCnt  = 0;
      errCnt    = 0;
      repeat (3) @(posedge clk);
      arstN <= 1'b1;
      resetTest();
      memTest();
      wrTestCycleTest();
      msrTest();
      ignoreTest();
      $display("%0d checks, %0d errors", checkCnt, errCnt);
      if (errCnt == 0)
      begin
         $display("All checks passed");
      end
      else
      begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

//--- sim/ks10Mem_properties.sv
// Concurrent checks on phase rotation, SRAM strobes and bus acknowledge, bound into the top level
`timescale 1ns/1ps

module ks10MemProperties
(
   input logic                 clk,
   input logic                 arstN,
   input logic                 busReq,
   input logic                 busAck,
   input ks10MemPkg::phaseT    clkPhs,
   input ks10MemPkg::ssramCtlT ssramCtl
);

   phaseOneHot: assert property (@(posedge clk) disable iff (!arstN) $onehot(clkPhs))
      else $error("clkPhs is not one-hot: %b", clkPhs);

   // Write command only in phase 2
   weInPhase2: assert property (@(posedge clk) disable iff (!arstN) !ssramCtl.weN |-> clkPhs[1])
      else $error("SRAM write enable low outside phase 2");

   // Data drive only in phase 4
   oeInPhase4: assert property (@(posedge clk) disable iff (!arstN) ssramCtl.dataOe |-> clkPhs[3])
      else $error("SRAM data driven outside phase 4");

   ackNeedsReq: assert property (@(posedge clk) disable iff (!arstN) busAck |-> busReq)
      else $error("Acknowledge without a request");

endmodule

bind ks10Mem ks10MemProperties props (
   .clk      (clk),
   .arstN    (arstN),
   .busReq   (busReq),
   .busAck   (busAck),
   .clkPhs   (clkPhs),
   .ssramCtl (ssramCtl)
);

//--- sim/ssramModel.sv
// Behavioral 1 MW ZBT SRAM for simulation; pipelined, two edges from command to data
`timescale 1ns/1ps

module ssramModel
(
   input  logic                 clk,
   input  ks10MemPkg::ssramCtlT ssramCtl,
   output ks10MemPkg::wordT     ssramDataIn
);

   ks10MemPkg::wordT    mem [0:(1 << ks10MemPkg::memAddrW) - 1];
   ks10MemPkg::memAddrT addrQ1;         // Captured address
   ks10MemPkg::memAddrT addrQ2;
   logic                wrQ1;           // Captured write command
   logic                wrQ2;
   ks10MemPkg::wordT    rdQ;            // Output register

   always @(posedge clk)
   begin
      addrQ1 <= ssramCtl.addr[ks10MemPkg::memAddrW-1:0];   // Upper pins always zero
      wrQ1   <= ~ssramCtl.weN;
      addrQ2 <= addrQ1;
      wrQ2   <= wrQ1;
      // Late write lands two edges after the command
      if (wrQ2)
      begin
         mem[addrQ2] <= ssramCtl.dataOe ? ssramCtl.dataOut : 'x;
      end
      rdQ <= mem[addrQ2];
   end

   // Controller drive wins on the shared data pins
   assign ssramDataIn = ssramCtl.dataOe ? ssramCtl.dataOut : rdQ;

endmodule

//--- rtl/ks10Mem.sv
// Top level of the memory subsystem; phase generator plus controller, for use on the bus
`timescale 1ns/1ps

module ks10Mem
(
   input  logic                 clk,
   input  logic                 arstN,
   input  logic                 busReq,
   input  ks10MemPkg::busAddrT  busAddr,
   input  ks10MemPkg::wordT     busDataIn,
   output logic                 busAck,
   output ks10MemPkg::wordT     busDataOut,
   output ks10MemPkg::phaseT    clkPhs,      // Masters align to phase 1
   output ks10MemPkg::ssramCtlT ssramCtl,
   input  ks10MemPkg::wordT     ssramDataIn
);

   clockPhase u_clockPhase (
      .clk   (clk),
      .arstN (arstN),
      .phase (clkPhs)
   );

   memController u_memController (
      .clk         (clk),
      .arstN       (arstN),
      .phase       (clkPhs),
      .busReq      (busReq),
      .busAddr     (busAddr),
      .busDataIn   (busDataIn),
      .busAck      (busAck),
      .busDataOut  (busDataOut),
      .ssramCtl    (ssramCtl),
      .ssramDataIn (ssramDataIn)
   );

endmodule

//--- rtl/memController.sv
// Memory interface block; decodes bus cycles, holds the MSR, drives the SRAM and acknowledges
`timescale 1ns/1ps

module memController
(
   input  logic                 clk,
   input  logic                 arstN,
   input  ks10MemPkg::phaseT    phase,
   input  logic                 busReq,
   input  ks10MemPkg::busAddrT  busAddr,
   input  ks10MemPkg::wordT     busDataIn,
   output logic                 busAck,
   output ks10MemPkg::wordT     busDataOut,
   output ks10MemPkg::ssramCtlT ssramCtl,
   input  ks10MemPkg::wordT     ssramDataIn
);

   ks10MemPkg::cycleT cycle;
   ks10MemPkg::wordT  regStat;

   busDecode u_busDecode (
      .busReq  (busReq),
      .busAddr (busAddr),
      .cycle   (cycle)
   );

   memStatus u_memStatus (
      .clk       (clk),
      .arstN     (arstN),
      .phase     (phase),
      .msrWrite  (cycle.msrWrite),
      .busDataIn (busDataIn),
      .regStat   (regStat)
   );

   ssramPort u_ssramPort (
      .phase     (phase),
      .memWrite  (cycle.memWrite),
      .busAddr   (busAddr),
      .busDataIn (busDataIn),
      .ssramCtl  (ssramCtl)
   );

   // IO cycles only ever hit the MSR
   assign busDataOut = cycle.isIo ? regStat : ssramDataIn;

   // Any owned cycle acks in the same clock as the request
   assign busAck = cycle.msrRead | cycle.msrWrite
                 | cycle.memRead | cycle.memWrite | cycle.memWrTest;

endmodule

//--- rtl/ssramPort.sv
// Forms the ZBT SRAM address, write enable and data drive from the bus cycle and phase
`timescale 1ns/1ps

module ssramPort
(
   input  ks10MemPkg::phaseT    phase,
   input  logic                 memWrite,
   input  ks10MemPkg::busAddrT  busAddr,
   input  ks10MemPkg::wordT     busDataIn,
   output ks10MemPkg::ssramCtlT ssramCtl
);

   ////////////////////////////////////////////////////////////////////////////
   // Address
   ////////////////////////////////////////////////////////////////////////////

   ks10MemPkg::memAddrT memAddr;
   logic                wrCmd;
   logic                wrData;

   assign memAddr = busAddr[ks10MemPkg::memAddrW-1:0];

   ////////////////////////////////////////////////////////////////////////////
   // Write timing
   ////////////////////////////////////////////////////////////////////////////

   // ZBT part takes the command in phase 2 and the data two edges later in phase 4
   assign wrCmd  = memWrite & phase[1];
   assign wrData = memWrite & phase[3];

   always_comb
   begin
      // Address every clock, so reads see data in phase 4
      ssramCtl.addr    = ks10MemPkg::ssramAddrT'(memAddr);   // Zero-extend to 23 bits
      ssramCtl.weN     = ~wrCmd;
      ssramCtl.dataOe  = wrData;
      ssramCtl.dataOut = wrData ? busDataIn : '0;            // Quiet when not driving
   end

endmodule

//--- rtl/memStatus.sv
// Memory status register with masked writable field and a write-one-to-clear power-fail flag
`timescale 1ns/1ps

module memStatus
(
   input  logic              clk,
   input  logic              arstN,
   input  ks10MemPkg::phaseT phase,
   input  logic              msrWrite,
   input  ks10MemPkg::wordT  busDataIn,
   output ks10MemPkg::wordT  regStat
);

   ks10MemPkg::wordT wrBits;            // KS10 bits 0..11 only
   logic             powerFail;
   logic             load;

   // Commit at the edge that ends phase 4
   assign load = msrWrite & phase[3];

   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         wrBits    <= ks10MemPkg::msrReset & ks10MemPkg::msrWriteMask;
         powerFail <= ks10MemPkg::msrReset[ks10MemPkg::msrPowerFail];   // Set at power up
      end
      else if (load)
      begin
         wrBits <= busDataIn & ks10MemPkg::msrWriteMask;
         if (busDataIn[ks10MemPkg::msrPowerFail])
         begin
            powerFail <= 1'b0;          // W1C
         end
      end
   end

   // Unused bits read back as zero
   assign regStat = wrBits
                  | (ks10MemPkg::wordT'(powerFail) << ks10MemPkg::msrPowerFail);

endmodule

//--- rtl/busDecode.sv
// Decodes the flag field of a bus address word into memory and MSR cycle strobes
`timescale 1ns/1ps

module busDecode
(
   input  logic                busReq,
   input  ks10MemPkg::busAddrT busAddr,
   output ks10MemPkg::cycleT   cycle
);

   logic               isRead;
   logic               isWrTest;
   logic               isWrite;
   logic               isPhys;
   logic               isIo;
   ks10MemPkg::devT    dev;
   ks10MemPkg::ioAddrT ioAddr;
   logic               msrHit;

   // Flag fields
   assign isRead   = busAddr[ks10MemPkg::flagRead];
   assign isWrTest = busAddr[ks10MemPkg::flagWrTest];
   assign isWrite  = busAddr[ks10MemPkg::flagWrite];
   assign isPhys   = busAddr[ks10MemPkg::flagPhys];
   assign isIo     = busAddr[ks10MemPkg::flagIo];
   assign dev      = busAddr[ks10MemPkg::devLsb +: ks10MemPkg::devW];
   assign ioAddr   = busAddr[ks10MemPkg::ioAddrW-1:0];

   // Physical IO to device 0 at address 100000
   assign msrHit = busReq & isIo & isPhys
                 & (dev == ks10MemPkg::memDev)
                 & (ioAddr == ks10MemPkg::msrAddr);

   always_comb
   begin
      cycle.msrRead   = msrHit & isRead;
      cycle.msrWrite  = msrHit & isWrite;
      // Memory needs only a request and no IO flag
      cycle.memRead   = busReq & ~isIo & isRead;
      cycle.memWrite  = busReq & ~isIo & isWrite;
      cycle.memWrTest = busReq & ~isIo & isWrTest;   // Read-like and never writes
      cycle.isIo      = isIo;                        // Mux select only
   end

endmodule

//--- rtl/clockPhase.sv
// Rotating one-hot phase generator; the sole timing source for four-clock bus cycles
`timescale 1ns/1ps

module clockPhase
(
   input  logic              clk,
   input  logic              arstN,
   output ks10MemPkg::phaseT phase       // Bit 0 is phase 1
);

   // Phase 1 in the first clock after reset
   always_ff @(posedge clk or negedge arstN)
   begin
      if (!arstN)
      begin
         phase <= ks10MemPkg::phase1;
      end
      else
      begin
         // Rotate left and wrap from 4 to 1
         phase <= {phase[ks10MemPkg::phaseW-2:0], phase[ks10MemPkg::phaseW-1]};
      end
   end

endmodule

//--- rtl/ks10MemPkg.sv
// Shared widths, bus flag positions, MSR constants and structs for the KS10 memory controller
package ks10MemPkg;

   ////////////////////////////////////////////////////////////////////////////
   // Widths
   ////////////////////////////////////////////////////////////////////////////

   localparam int wordW      = 36;        // Backplane data word
   localparam int memAddrW   = 20;        // 1 MW of SRAM
   localparam int ssramAddrW = 23;        // Board address pins
   localparam int devW       = 4;
   localparam int ioAddrW    = 18;
   localparam int phaseW     = 4;         // Four clocks per bus cycle

   typedef logic [wordW-1:0]      wordT;
   typedef logic [wordW-1:0]      busAddrT;     // Flags 35..22, address below
   typedef logic [memAddrW-1:0]   memAddrT;
   typedef logic [ssramAddrW-1:0] ssramAddrT;   // Top 3 bits always zero
   typedef logic [devW-1:0]       devT;
   typedef logic [ioAddrW-1:0]    ioAddrT;
   typedef logic [phaseW-1:0]     phaseT;       // One-hot with bit 0 as phase 1

   // Flag positions in the bus address word (KS10 bit n is bit 35-n)
   localparam int flagRead   = 35;
   localparam int flagWrTest = 34;
   localparam int flagWrite  = 33;
   localparam int flagPhys   = 32;
   localparam int flagIo     = 31;
   localparam int devLsb     = 18;         // Base of the device field

   localparam phaseT phase1  = 4'b0001;    // Reset phase

   ////////////////////////////////////////////////////////////////////////////
   // Memory status register
   ////////////////////////////////////////////////////////////////////////////

   localparam devT    memDev       = 4'd0;
   localparam ioAddrT msrAddr      = 18'o100000;
   localparam wordT   msrWriteMask = 36'o777700000000;   // KS10 bits 0..11
   localparam int     msrPowerFail = 23;                 // KS10 bit 12
   localparam wordT   msrReset     = wordT'(1) << msrPowerFail;

   // Decoded bus cycle
   typedef struct packed {
      logic msrRead;
      logic msrWrite;
      logic memRead;
      logic memWrite;
      logic memWrTest;
      logic isIo;                          // Steers the read mux
   } cycleT;

   // SRAM pins that the controller actually drives
   typedef struct packed {
      logic      weN;
      logic      dataOe;
      ssramAddrT addr;
      wordT      dataOut;
   } ssramCtlT;

endpackage
